/* list.f */
rtl/cache_pkg.sv
rtl/mem_pkg.sv
rtl/cache_way.sv
rtl/victim_reg.sv
rtl/main_mem.sv
rtl/cache_ctrl.sv
rtl/mem_system.sv
tb/tb_mem_system.sv

/* rtl/cache_ctrl.sv */
`timescale 1ns/1ps

module cache_ctrl (
    input  logic                          clk,
    input  logic                          rst_n,
    input  mem_pkg::cpu_req_t             cpu_req,
    output mem_pkg::cpu_resp_t            cpu_resp,
    output cache_pkg::way_cmd_t           way_cmd,
    output logic [1:0]                    way_en,
    input  cache_pkg::way_stat_t          stat0,
    input  cache_pkg::way_stat_t          stat1,
    input  logic                          victim,
    output logic                          victim_flip,
    output logic [cache_pkg::index_w-1:0] victim_index,
    output mem_pkg::mem_req_t             mem_req,
    input  logic [15:0]                   mem_rdata
);
    import cache_pkg::*;

    typedef enum logic [3:0] {
        idle, compare_rd, compare_wr,
        b0, b1, b2, b3,
        f0, f1, f2, f3, f4, f5
    } state_t;

    state_t              state_q;
    state_t              state_d;
    cache_addr_u         req_addr;
    way_stat_t           sel_stat;
    logic                in_compare;
    logic                hit_any;
    logic [15:0]         hit_rdata;
    logic                miss_way;
    logic                way_sel;
    logic [1:0]          way_one_hot;
    logic                fill_wr;
    logic                word_match;
    logic [15:0]         fill_data;
    logic [offset_w-1:0] mem_off;
    logic [offset_w-1:0] way_off;
    logic                way_q;        // Way chosen on the miss
    logic                is_wr_q;
    logic [tag_w-1:0]    vtag_q;
    logic [15:0]         rdata_q;

    assign req_addr.flat = cpu_req.addr;
    assign victim_index  = req_addr.fields.index;

    assign in_compare = (state_q == compare_rd) || (state_q == compare_wr);
    assign hit_any    = stat0.hit || stat1.hit;
    assign hit_rdata  = stat1.hit ? stat1.rdata : stat0.rdata;

    // Invalid way first, way 0 before way 1, then the victim bit
    assign miss_way    = !stat0.valid ? 1'b0 : (!stat1.valid ? 1'b1 : victim);
    assign way_sel     = in_compare ? miss_way : way_q;
    assign sel_stat    = way_sel ? stat1 : stat0;
    assign way_one_hot = way_q ? 2'b10 : 2'b01;

    // Memory word runs two states ahead of the way word during fetch
    always_comb begin
        mem_off = {2'(state_q - f0), 1'b0};
        way_off = {2'(state_q - f2), 1'b0};
        if (state_q inside {[b0:b3]}) begin
            mem_off = {2'(state_q - b0), 1'b0};
            way_off = mem_off;
        end
    end

    assign fill_wr    = state_q inside {[f2:f5]};
    assign word_match = (req_addr.fields.offset == way_off);
    assign fill_data  = (is_wr_q && word_match) ? cpu_req.wdata : mem_rdata;

    always_comb begin
        state_d            = state_q;
        way_en             = 2'b00;
        way_cmd            = '0;
        way_cmd.index      = req_addr.fields.index;
        way_cmd.tag        = req_addr.fields.tag;
        way_cmd.offset     = req_addr.fields.offset;
        mem_req            = '0;
        cpu_resp.rdata     = rdata_q;
        cpu_resp.done      = 1'b0;
        cpu_resp.stall     = (state_q != idle);
        cpu_resp.cache_hit = 1'b0;
        victim_flip        = 1'b0;

        case (state_q)
            idle: begin
                if (cpu_req.rd) begin
                    state_d = compare_rd;
                end else if (cpu_req.wr) begin
                    state_d = compare_wr;
                end
            end
            compare_rd, compare_wr: begin
                way_en             = 2'b11;
                way_cmd.comp       = 1'b1;
                way_cmd.write      = (state_q == compare_wr);  // Lands only in the hit way
                way_cmd.wdata      = cpu_req.wdata;
                cpu_resp.done      = hit_any;
                cpu_resp.cache_hit = hit_any;
                cpu_resp.rdata     = hit_rdata;
                if (hit_any) begin
                    state_d = idle;
                end else if (sel_stat.valid && sel_stat.dirty) begin
                    state_d = b0;
                end else begin
                    state_d = f0;
                end
            end
            b0, b1, b2, b3: begin
                way_en         = way_one_hot;
                way_cmd.offset = way_off;
                mem_req.wr     = 1'b1;
                mem_req.addr   = {vtag_q, req_addr.fields.index, mem_off};
                mem_req.wdata  = sel_stat.rdata;
                state_d        = state_t'(state_q + 4'd1);  // b3 runs into f0
            end
            f0, f1, f2, f3, f4, f5: begin
                if (state_q inside {[f0:f3]}) begin
                    mem_req.rd   = 1'b1;
                    mem_req.addr = {req_addr.fields.tag, req_addr.fields.index, mem_off};
                end
                if (fill_wr) begin
                    way_en           = way_one_hot;
                    way_cmd.write    = 1'b1;
                    way_cmd.valid_in = 1'b1;
                    // Last word of a write miss goes in as a hit to mark it dirty
                    way_cmd.comp     = (state_q == f5) && is_wr_q;
                    way_cmd.offset   = way_off;
                    way_cmd.wdata    = fill_data;
                    if (!is_wr_q && word_match) begin
                        cpu_resp.rdata = mem_rdata;
                    end
                end
                if (state_q == f5) begin
                    cpu_resp.done = 1'b1;
                    victim_flip   = 1'b1;
                    state_d       = idle;
                end else begin
                    state_d = state_t'(state_q + 4'd1);
                end
            end
            default: begin
                state_d = idle;
            end
        endcase
    end

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            state_q <= idle;
            way_q   <= 1'b0;
            is_wr_q <= 1'b0;
        end else begin
            state_q <= state_d;
            if (in_compare) begin
                way_q   <= miss_way;
                is_wr_q <= (state_q == compare_wr);
            end
        end
    end

    always_ff @(posedge clk) begin
        if (in_compare) begin
            vtag_q <= sel_stat.tag_out;  // Write-back address of the victim
        end
        if (in_compare && hit_any) begin
            rdata_q <= hit_rdata;
        end else if (fill_wr && !is_wr_q && word_match) begin
            rdata_q <= mem_rdata;
        end
    end

endmodule

/* rtl/cache_pkg.sv */
package cache_pkg;

    // Address split of the 16-bit byte address
    localparam int tag_w          = 5;
    localparam int index_w        = 8;
    localparam int offset_w       = 3;
    localparam int num_sets       = 256;
    localparam int words_per_line = 4;

    typedef struct packed {
        logic [tag_w-1:0]    tag;
        logic [index_w-1:0]  index;
        logic [offset_w-1:0] offset;
    } cache_addr_fields_t;

    // Same 16 bits seen flat or split into fields
    typedef union packed {
        logic [15:0]        flat;
        cache_addr_fields_t fields;
    } cache_addr_u;

    // Sent to both ways and gated by each way's enable
    typedef struct packed {
        logic                comp;     // Compare access
        logic                write;
        logic                valid_in;
        logic [index_w-1:0]  index;
        logic [offset_w-1:0] offset;
        logic [tag_w-1:0]    tag;
        logic [15:0]         wdata;
    } way_cmd_t;

    typedef struct packed {
        logic             hit;         // Valid and tag match during comp
        logic             valid;
        logic             dirty;
        logic [tag_w-1:0] tag_out;
        logic [15:0]      rdata;
    } way_stat_t;

endpackage

/* rtl/cache_way.sv */
`timescale 1ns/1ps

module cache_way (
    input  logic                 clk,
    input  logic                 rst_n,
    input  logic                 en,
    input  cache_pkg::way_cmd_t  cmd,
    output cache_pkg::way_stat_t stat
);
    import cache_pkg::*;

    localparam int word_w = $clog2(words_per_line);

    logic [tag_w-1:0]          tag_mem  [num_sets];
    logic [15:0]               data_mem [num_sets*words_per_line];
    logic [num_sets-1:0]       valid_q;
    logic [num_sets-1:0]       dirty_q;
    logic [index_w+word_w-1:0] word_addr;
    logic                      tag_match;
    logic                      hit;
    logic                      fill_wr;
    logic                      data_wr;

    // Accesses are word aligned so byte offset bit 0 is dropped
    assign word_addr = {cmd.index, cmd.offset[offset_w-1 -: word_w]};

    assign tag_match = (tag_mem[cmd.index] == cmd.tag);
    assign hit       = en && cmd.comp && valid_q[cmd.index] && tag_match;
    assign fill_wr   = en && cmd.write && !cmd.comp;  // Line fill from memory
    assign data_wr   = fill_wr || (hit && cmd.write);

    always_comb begin
        stat.hit     = hit;
        stat.valid   = valid_q[cmd.index];
        stat.dirty   = dirty_q[cmd.index];
        stat.tag_out = tag_mem[cmd.index];
        stat.rdata   = data_mem[word_addr];
    end

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            valid_q <= '0;
            dirty_q <= '0;
        end else if (fill_wr) begin
            valid_q[cmd.index] <= cmd.valid_in;
            dirty_q[cmd.index] <= 1'b0;           // Fill word leaves line clean
        end else if (hit && cmd.write) begin
            dirty_q[cmd.index] <= 1'b1;
        end
    end

    always_ff @(posedge clk) begin
        if (data_wr) begin
            data_mem[word_addr] <= cmd.wdata;
        end
        if (fill_wr) begin
            tag_mem[cmd.index] <= cmd.tag;
        end
    end

endmodule

/* rtl/main_mem.sv */
`timescale 1ns/1ps

module main_mem #(
    parameter int MEM_WORDS = 32768
) (
    input  logic              clk,
    input  mem_pkg::mem_req_t req,
    output logic [15:0]       rdata
);

    logic [15:0] mem [MEM_WORDS];
    logic [14:0] word_addr;
    logic [15:0] rd_stage;

    // Word address wraps when the array is smaller than the space
    assign word_addr = 15'(req.addr[15:1] % MEM_WORDS);

    always_ff @(posedge clk) begin
        if (req.wr) begin
            mem[word_addr] <= req.wdata;  // Posted write
        end
    end

    // Two registered stages put read data two cycles after the strobe
    always_ff @(posedge clk) begin
        if (req.rd) begin
            rd_stage <= mem[word_addr];
        end
        rdata <= rd_stage;
    end

endmodule

/* rtl/mem_pkg.sv */
package mem_pkg;

    // CPU holds rd and wr until done
    typedef struct packed {
        logic        rd;
        logic        wr;
        logic [15:0] addr;
        logic [15:0] wdata;
    } cpu_req_t;

    typedef struct packed {
        logic [15:0] rdata;
        logic        done;
        logic        stall;
        logic        cache_hit;
    } cpu_resp_t;

    // One strobe per word toward the word memory
    typedef struct packed {
        logic        rd;
        logic        wr;
        logic [15:0] addr;
        logic [15:0] wdata;
    } mem_req_t;

endpackage

/* rtl/mem_system.sv */
`timescale 1ns/1ps

module mem_system #(
    parameter int MEM_WORDS = 32768
) (
    input  logic               clk,
    input  logic               rst_n,
    input  mem_pkg::cpu_req_t  req,
    output mem_pkg::cpu_resp_t resp
);
    import cache_pkg::*;
    import mem_pkg::*;

    way_cmd_t           way_cmd;
    logic [1:0]         way_en;
    way_stat_t          stat0;
    way_stat_t          stat1;
    logic               victim;
    logic               victim_flip;
    logic [index_w-1:0] victim_index;
    mem_req_t           mem_req;
    logic [15:0]        mem_rdata;

    cache_ctrl ctrl0 (
        .clk          (clk),
        .rst_n        (rst_n),
        .cpu_req      (req),
        .cpu_resp     (resp),
        .way_cmd      (way_cmd),
        .way_en       (way_en),
        .stat0        (stat0),
        .stat1        (stat1),
        .victim       (victim),
        .victim_flip  (victim_flip),
        .victim_index (victim_index),
        .mem_req      (mem_req),
        .mem_rdata    (mem_rdata)
    );

    cache_way way0 (
        .clk   (clk),
        .rst_n (rst_n),
        .en    (way_en[0]),
        .cmd   (way_cmd),
        .stat  (stat0)
    );

    cache_way way1 (
        .clk   (clk),
        .rst_n (rst_n),
        .en    (way_en[1]),
        .cmd   (way_cmd),
        .stat  (stat1)
    );

    victim_reg victim0 (
        .clk    (clk),
        .rst_n  (rst_n),
        .index  (victim_index),
        .flip   (victim_flip),
        .victim (victim)
    );

    main_mem #(
        .MEM_WORDS (MEM_WORDS)
    ) mem0 (
        .clk   (clk),
        .req   (mem_req),
        .rdata (mem_rdata)
    );

endmodule

/* rtl/victim_reg.sv */
`timescale 1ns/1ps

module victim_reg (
    input  logic                          clk,
    input  logic                          rst_n,
    input  logic [cache_pkg::index_w-1:0] index,
    input  logic                          flip,
    output logic                          victim
);
    import cache_pkg::*;

    logic [num_sets-1:0] victim_q;   // A set bit of 1 selects way 1

    assign victim = victim_q[index];

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            victim_q <= '0;
        end else if (flip) begin
            victim_q[index] <= ~victim_q[index];
        end
    end

endmodule

/* tb/mem_system_input.txt */
# op addr wdata exp_rdata exp_hit   (op r or w, then hex words, hit 0 or 1)
# exp_rdata is checked on reads only
w 0008 1111 0000 0
r 0008 0000 1111 1
w 000a 1212 0000 1
w 000c 1313 0000 1
w 000e 1414 0000 1
w 000a 1a1a 0000 1
r 000c 0000 1313 1
w 080e 2626 0000 0
r 0008 0000 1111 1
r 080e 0000 2626 1
w 100c 3434 0000 0
r 0008 0000 1111 0
r 080e 0000 2626 0
r 100c 0000 3434 0
r 000a 0000 1a1a 0
r 100c 0000 3434 1
r 000e 0000 1414 1
r 080e 0000 2626 0
r 000c 0000 1313 1
r 100c 0000 3434 0

/* tb/tb_mem_system.sv */
`timescale 1ns/1ps

module tb_mem_system;
    import mem_pkg::*;

    typedef struct packed {
        logic        is_wr;
        logic [15:0] addr;
        logic [15:0] wdata;
        logic [15:0] exp_rdata;
        logic        exp_hit;
    } op_t;

    localparam int max_ops = 64;

    logic      clk;
    logic      rst_n;
    cpu_req_t  req;
    cpu_resp_t resp;
    op_t       ops [max_ops];
    int        num_ops;
    logic      ops_loaded;
    int        mismatch_count;
    int        error_count;

    mem_system dut0 (
        .clk   (clk),
        .rst_n (rst_n),
        .req   (req),
        .resp  (resp)
    );

    initial begin
        clk = 1'b0;
        forever #10 clk = ~clk;
    end

    // One access per line with # lines skipped
    task automatic load_ops();
        int               fd;
        int               n;
        logic [63:0]      tok;
        logic [8*128-1:0] line_buf;
        logic [15:0]      addr;
        logic [15:0]      wdata;
        logic [15:0]      rdata;
        int               hit;
        op_t              op;
        fd = $fopen("tb/mem_system_input.txt", "r");
        if (fd == 0) begin
            $display("ERROR: cannot open tb/mem_system_input.txt");
            error_count++;
            return;
        end
        while (!$feof(fd)) begin
            n = $fscanf(fd, "%s", tok);
            if (n == 1) begin
                if (tok[7:0] == "#") begin
                    n = $fgets(line_buf, fd);
                end else begin
                    n = $fscanf(fd, "%h %h %h %d", addr, wdata, rdata, hit);
                    if (n != 4 || (tok[7:0] != "r" && tok[7:0] != "w")) begin
                        $display("ERROR: malformed line after operation %0d", num_ops);
                        error_count++;
                    end else if (num_ops >= max_ops) begin
                        $display("ERROR: more than %0d operations in the input file", max_ops);
                        error_count++;
                    end else begin
                        op.is_wr      = (tok[7:0] == "w");
                        op.addr       = addr;
                        op.wdata      = wdata;
                        op.exp_rdata  = rdata;
                        op.exp_hit    = (hit != 0);
                        ops[num_ops]  = op;
                        num_ops++;
                    end
                end
            end
        end
        $fclose(fd);
    endtask

    // Called on a falling edge with the DUT idle
    task automatic run_op(input op_t op, input int idx);
        int cycles;
        req.rd    = !op.is_wr;
        req.wr    = op.is_wr;
        req.addr  = op.addr;
        req.wdata = op.wdata;
        @(negedge clk);
        cycles = 1;
        while (!resp.done && resp.stall) begin
            @(negedge clk);
            cycles++;
        end
        if (!resp.stall) begin
            $display("ERROR: t=%0t op %0d addr %h: controller went idle without done",
                     $time, idx, op.addr);
            error_count++;
        end else begin
            if (!op.is_wr && resp.rdata !== op.exp_rdata) begin
                $display("MISMATCH t=%0t op %0d addr %h: rdata got %h expected %h",
                         $time, idx, op.addr, resp.rdata, op.exp_rdata);
                mismatch_count++;
            end
            if (resp.cache_hit !== op.exp_hit) begin
                $display("MISMATCH t=%0t op %0d addr %h: cache_hit got %b expected %b",
                         $time, idx, op.addr, resp.cache_hit, op.exp_hit);
                mismatch_count++;
            end
            // Hit in 1 cycle, clean miss 7, dirty miss 11
            if ((op.exp_hit && cycles != 1) ||
                (!op.exp_hit && cycles != 7 && cycles != 11)) begin
                $display("ERROR: t=%0t op %0d addr %h: done came after %0d cycles",
                         $time, idx, op.addr, cycles);
                error_count++;
            end
        end
        @(negedge clk);
        req = '0;
    endtask

    initial begin
        ops_loaded     = 1'b0;
        num_ops        = 0;
        mismatch_count = 0;
        error_count    = 0;
        rst_n          = 1'b0;
        req            = '0;
        load_ops();
        ops_loaded = 1'b1;
        repeat (2) @(posedge clk);
        @(negedge clk);
        rst_n = 1'b1;
        if (resp.stall !== 1'b0) begin
            $display("MISMATCH t=%0t stall: got %b expected 0", $time, resp.stall);
            mismatch_count++;
        end
        if (resp.done !== 1'b0) begin
            $display("MISMATCH t=%0t done: got %b expected 0", $time, resp.done);
            mismatch_count++;
        end
        if (resp.cache_hit !== 1'b0) begin
            $display("MISMATCH t=%0t cache_hit: got %b expected 0", $time, resp.cache_hit);
            mismatch_count++;
        end
        for (int i = 0; i < num_ops; i++) begin
            run_op(ops[i], i);
        end
        $display("tb_mem_system: %0d operations, %0d mismatches, %0d other errors",
                 num_ops, mismatch_count, error_count);
        if (mismatch_count == 0 && error_count == 0) begin
            $display("*** PASSED ***");
        end else begin
            $display("*** FAILED ***");
        end
        $finish;
    end

    // Worst case is a dirty miss plus the idle cycle between requests
    initial begin
        wait (ops_loaded === 1'b1);
        repeat (12 * num_ops + 50) @(posedge clk);
        $display("ERROR: watchdog expired after %0d cycles, done never came",
                 12 * num_ops + 50);
        $display("tb_mem_system: %0d operations, %0d mismatches, %0d other errors",
                 num_ops, mismatch_count, error_count + 1);
        $display("*** FAILED ***");
        $finish;
    end

endmodule
